//--- Makefile
# Verilator build for the gesture tracker testbench

TOP = tb_gesture_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f files.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

//--- blob_accumulator.sv
`default_nettype none

module blob_accumulator
    import tracker_pkg::*;
#(
    parameter marker_t marker = marker_red
) (
    input  wire logic                   clk_65mhz,
    input  wire logic                   rst,
    input  wire logic [11:0]            pixel,
    input  wire logic                   pixel_valid,
    input  wire logic [x_width-1:0]     x,
    input  wire logic [y_width-1:0]     y,
    input  wire logic                   frame_done,
    input  wire logic                   div_grant,
    output logic                        div_req,
    output axis_t                       div_axis,
    output logic [sum_width-1:0]        div_sum,
    output logic [count_width-1:0]      div_count
);

    logic is_red;
    logic is_white;
    logic is_marker;

    // registered pixel hit and its coordinates
    logic                 hit_q;
    logic [x_width-1:0]   x_q;
    logic [y_width-1:0]   y_q;
    logic                 frame_done_q;

    // running totals for the frame in progress
    logic [sum_width-1:0]   run_x_sum;
    logic [sum_width-1:0]   run_y_sum;
    logic [count_width-1:0] run_count;

    // totals of the finished frame, held for the divider
    logic [sum_width-1:0]   x_sum_l;
    logic [sum_width-1:0]   y_sum_l;

    // channel compares, R in [11:8], G in [7:4], B in [3:0]
    assign is_red = (pixel[11:8] > colour_hi) && (pixel[7:4] < colour_lo) &&
                    (pixel[3:0] < colour_lo);
    assign is_white = (pixel[11:8] > colour_hi) && (pixel[7:4] > colour_hi) &&
                      (pixel[3:0] > colour_hi);
    assign is_marker = (marker == marker_red) ? is_red : is_white;

    // pixel stage, frame_done cycle never counts
    always_ff @(posedge clk_65mhz) begin
        if (rst) begin
            hit_q <= 1'b0;
            frame_done_q <= 1'b0;
        end else begin
            hit_q <= pixel_valid && !frame_done && is_marker;
            frame_done_q <= frame_done;
        end
        x_q <= x;
        y_q <= y;
    end

    // accumulate, then latch and restart one cycle after frame_done
    always_ff @(posedge clk_65mhz) begin
        if (rst) begin
            run_x_sum <= '0;
            run_y_sum <= '0;
            run_count <= '0;
        end else if (frame_done_q) begin
            run_x_sum <= '0;
            run_y_sum <= '0;
            run_count <= '0;
        end else if (hit_q) begin
            run_x_sum <= run_x_sum + sum_width'(x_q);
            run_y_sum <= run_y_sum + sum_width'(y_q);
            run_count <= run_count + 1'b1;
        end
    end

    // finished-frame totals
    always_ff @(posedge clk_65mhz) begin
        if (frame_done_q) begin
            x_sum_l <= run_x_sum;
            y_sum_l <= run_y_sum;
            div_count <= run_count;
        end
    end

    // request x first, then y; hold until granted
    always_ff @(posedge clk_65mhz) begin
        if (rst) begin
            div_req <= 1'b0;
            div_axis <= axis_x;
        end else if (frame_done_q) begin
            div_req <= run_count > min_blob_pixels;
            div_axis <= axis_x;
        end else if (div_req && div_grant) begin
            if (div_axis == axis_x) begin
                div_axis <= axis_y;
            end else begin
                div_req <= 1'b0;
            end
        end
    end

    assign div_sum = (div_axis == axis_x) ? x_sum_l : y_sum_l;

endmodule

`default_nettype wire

//--- centroid_divider.sv
`default_nettype none

module centroid_divider
    import tracker_pkg::*;
(
    input  wire logic                   clk_65mhz,
    input  wire logic                   rst,
    input  wire logic                   start,
    input  wire logic [sum_width-1:0]   numerator,
    input  wire logic [count_width-1:0] denominator,
    output logic                        busy,
    output logic                        done,
    output logic [x_width-1:0]          quotient
);

    localparam logic [div_step_width-1:0] last_step = div_step_width'(sum_width - 1);

    logic [div_step_width-1:0] step;

    // dividend shifts out the top while quotient bits shift in below
    logic [sum_width-1:0]   quo;
    logic [count_width-1:0] rem;
    logic [count_width-1:0] den;

    // partial remainder with the next dividend bit, and the trial subtract
    logic [count_width:0]   shifted;
    logic [count_width+1:0] trial;

    assign shifted = {rem, quo[sum_width-1]};
    assign trial = {1'b0, shifted} - {2'b00, den};

    // control, 24 steps then done on the 25th cycle after start
    always_ff @(posedge clk_65mhz) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            step <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == last_step) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // restoring step, keep the difference only when it is not negative
    always_ff @(posedge clk_65mhz) begin
        if (start) begin
            quo <= numerator;
            rem <= '0;
            den <= denominator;
        end else if (busy) begin
            if (!trial[count_width+1]) begin
                rem <= trial[count_width-1:0];
                quo <= {quo[sum_width-2:0], 1'b1};
            end else begin
                rem <= shifted[count_width-1:0];
                quo <= {quo[sum_width-2:0], 1'b0};
            end
        end
    end

    // a centroid always fits the coordinate width, remainder dropped
    assign quotient = quo[x_width-1:0];

endmodule

`default_nettype wire

//--- divider_arbiter.sv
`default_nettype none

module divider_arbiter
    import tracker_pkg::*;
(
    input  wire logic                   clk_65mhz,
    input  wire logic                   rst,
    input  wire logic                   p1_req,
    input  wire axis_t                  p1_axis,
    input  wire logic [sum_width-1:0]   p1_sum,
    input  wire logic [count_width-1:0] p1_count,
    input  wire logic                   p2_req,
    input  wire axis_t                  p2_axis,
    input  wire logic [sum_width-1:0]   p2_sum,
    input  wire logic [count_width-1:0] p2_count,
    input  wire logic                   busy,
    input  wire logic                   done,
    input  wire logic [x_width-1:0]     quotient,
    output logic                        p1_grant,
    output logic                        p2_grant,
    output logic                        start,
    output logic [sum_width-1:0]        numerator,
    output logic [count_width-1:0]      denominator,
    output logic                        p1_coord_valid,
    output logic                        p2_coord_valid,
    output axis_t                       coord_axis,
    output logic [x_width-1:0]          coord
);

    // p2 goes first on the next tie
    logic  prio_p2;
    logic  pick_p2;
    // record of the job in the divider
    logic  owner_p2;
    axis_t job_axis;

    // p2 wins when alone or when it holds priority
    assign pick_p2 = p2_req && (!p1_req || prio_p2);

    // grants only while the divider is idle
    assign p1_grant = !busy && p1_req && !pick_p2;
    assign p2_grant = !busy && pick_p2;
    assign start = p1_grant || p2_grant;

    // operands of the winning player
    assign numerator = pick_p2 ? p2_sum : p1_sum;
    assign denominator = pick_p2 ? p2_count : p1_count;

    always_ff @(posedge clk_65mhz) begin
        if (rst) begin
            prio_p2 <= 1'b0;
            owner_p2 <= 1'b0;
            job_axis <= axis_x;
        end else if (start) begin
            // loser of this round gets priority next
            prio_p2 <= p1_grant;
            owner_p2 <= p2_grant;
            job_axis <= p2_grant ? p2_axis : p1_axis;
        end
    end

    // steer the result back to its owner
    assign p1_coord_valid = done && !owner_p2;
    assign p2_coord_valid = done && owner_p2;
    assign coord_axis = job_axis;
    assign coord = quotient;

endmodule

`default_nettype wire

//--- files.f
tracker_pkg.sv
blob_accumulator.sv
centroid_divider.sv
divider_arbiter.sv
motion_tracker.sv
gesture_top.sv
tb_gesture_top.sv

//--- gesture_top.sv
`default_nettype none

module gesture_top
    import tracker_pkg::*;
(
    input  wire logic                   clk_65mhz,
    input  wire logic                   rst,
    input  wire logic [11:0]            pixel,
    input  wire logic                   pixel_valid,
    input  wire logic [x_width-1:0]     x,
    input  wire logic [y_width-1:0]     y,
    input  wire logic                   frame_done,
    output logic                        p1_gesture_valid,
    output logic                        p1_punch,
    output logic                        p1_kick,
    output logic [motion_width-1:0]     p1_dx_mag,
    output logic                        p1_dx_neg,
    output logic [motion_width-1:0]     p1_dy_mag,
    output logic                        p1_dy_neg,
    output logic                        p2_gesture_valid,
    output logic                        p2_punch,
    output logic                        p2_kick,
    output logic [motion_width-1:0]     p2_dx_mag,
    output logic                        p2_dx_neg,
    output logic [motion_width-1:0]     p2_dy_mag,
    output logic                        p2_dy_neg
);

    // request side of each player
    logic                   p1_req;
    logic                   p2_req;
    axis_t                  p1_axis;
    axis_t                  p2_axis;
    logic [sum_width-1:0]   p1_sum;
    logic [sum_width-1:0]   p2_sum;
    logic [count_width-1:0] p1_count;
    logic [count_width-1:0] p2_count;
    logic                   p1_grant;
    logic                   p2_grant;

    // shared divider
    logic                   start;
    logic [sum_width-1:0]   numerator;
    logic [count_width-1:0] denominator;
    logic                   busy;
    logic                   done;
    logic [x_width-1:0]     quotient;

    // routed results
    logic                   p1_coord_valid;
    logic                   p2_coord_valid;
    axis_t                  coord_axis;
    logic [x_width-1:0]     coord;

    //////////////////////////////////////////////////////////////////////
    // marker detection, red for player 1 and white for player 2
    //////////////////////////////////////////////////////////////////////

    blob_accumulator #(.marker(marker_red)) p1_blob (
        .clk_65mhz(clk_65mhz), .rst(rst),
        .pixel(pixel), .pixel_valid(pixel_valid), .x(x), .y(y),
        .frame_done(frame_done), .div_grant(p1_grant),
        .div_req(p1_req), .div_axis(p1_axis),
        .div_sum(p1_sum), .div_count(p1_count)
    );

    blob_accumulator #(.marker(marker_white)) p2_blob (
        .clk_65mhz(clk_65mhz), .rst(rst),
        .pixel(pixel), .pixel_valid(pixel_valid), .x(x), .y(y),
        .frame_done(frame_done), .div_grant(p2_grant),
        .div_req(p2_req), .div_axis(p2_axis),
        .div_sum(p2_sum), .div_count(p2_count)
    );

    // one divider shared by both players
    divider_arbiter arbiter (
        .clk_65mhz(clk_65mhz), .rst(rst),
        .p1_req(p1_req), .p1_axis(p1_axis), .p1_sum(p1_sum), .p1_count(p1_count),
        .p2_req(p2_req), .p2_axis(p2_axis), .p2_sum(p2_sum), .p2_count(p2_count),
        .busy(busy), .done(done), .quotient(quotient),
        .p1_grant(p1_grant), .p2_grant(p2_grant),
        .start(start), .numerator(numerator), .denominator(denominator),
        .p1_coord_valid(p1_coord_valid), .p2_coord_valid(p2_coord_valid),
        .coord_axis(coord_axis), .coord(coord)
    );

    centroid_divider divider (
        .clk_65mhz(clk_65mhz), .rst(rst),
        .start(start), .numerator(numerator), .denominator(denominator),
        .busy(busy), .done(done), .quotient(quotient)
    );

    //////////////////////////////////////////////////////////////////////
    // per-player motion windows
    //////////////////////////////////////////////////////////////////////

    motion_tracker p1_motion (
        .clk_65mhz(clk_65mhz), .rst(rst), .frame_done(frame_done),
        .coord_valid(p1_coord_valid), .coord_axis(coord_axis), .coord(coord),
        .gesture_valid(p1_gesture_valid), .punch(p1_punch), .kick(p1_kick),
        .dx_mag(p1_dx_mag), .dx_neg(p1_dx_neg),
        .dy_mag(p1_dy_mag), .dy_neg(p1_dy_neg)
    );

    motion_tracker p2_motion (
        .clk_65mhz(clk_65mhz), .rst(rst), .frame_done(frame_done),
        .coord_valid(p2_coord_valid), .coord_axis(coord_axis), .coord(coord),
        .gesture_valid(p2_gesture_valid), .punch(p2_punch), .kick(p2_kick),
        .dx_mag(p2_dx_mag), .dx_neg(p2_dx_neg),
        .dy_mag(p2_dy_mag), .dy_neg(p2_dy_neg)
    );

endmodule

`default_nettype wire

//--- gesture_vectors.txt
# p1_x p1_y p1_side p2_x p2_y p2_side, one frame per line, p1 red and p2 white
# then p1 punch kick dx_mag dx_neg dy_mag dy_neg and the same for p2, read on every 16th frame
40 60 7 250 150 5 0 0 0 0 0 0 0 0 0 0 0 0
43 64 7 247 152 5 0 0 0 0 0 0 0 0 0 0 0 0
46 68 7 244 154 5 0 0 0 0 0 0 0 0 0 0 0 0
49 72 7 241 156 5 0 0 0 0 0 0 0 0 0 0 0 0
52 76 7 238 158 5 0 0 0 0 0 0 0 0 0 0 0 0
55 80 7 235 160 5 0 0 0 0 0 0 0 0 0 0 0 0
58 84 7 232 162 5 0 0 0 0 0 0 0 0 0 0 0 0
61 88 7 300 200 2 0 0 0 0 0 0 0 0 0 0 0 0
64 92 7 226 166 5 0 0 0 0 0 0 0 0 0 0 0 0
67 92 7 223 168 5 0 0 0 0 0 0 0 0 0 0 0 0
70 92 7 220 170 5 0 0 0 0 0 0 0 0 0 0 0 0
73 92 7 217 172 5 0 0 0 0 0 0 0 0 0 0 0 0
76 92 7 217 174 5 0 0 0 0 0 0 0 0 0 0 0 0
79 92 7 217 176 5 0 0 0 0 0 0 0 0 0 0 0 0
82 92 7 217 178 5 0 0 0 0 0 0 0 0 0 0 0 0
92 89 7 219 181 5 1 0 42 0 32 0 1 0 33 1 28 0
102 86 7 221 184 5 0 0 0 0 0 0 0 0 0 0 0 0
112 83 7 223 187 5 0 0 0 0 0 0 0 0 0 0 0 0
122 80 7 225 190 5 0 0 0 0 0 0 0 0 0 0 0 0
117 77 7 227 193 5 0 0 0 0 0 0 0 0 0 0 0 0
112 74 7 229 196 5 0 0 0 0 0 0 0 0 0 0 0 0
107 71 7 231 199 5 0 0 0 0 0 0 0 0 0 0 0 0
102 68 7 233 202 5 0 0 0 0 0 0 0 0 0 0 0 0
97 65 7 235 205 5 0 0 0 0 0 0 0 0 0 0 0 0
92 62 7 237 208 5 0 0 0 0 0 0 0 0 0 0 0 0
87 59 7 239 211 5 0 0 0 0 0 0 0 0 0 0 0 0
82 56 7 241 214 5 0 0 0 0 0 0 0 0 0 0 0 0
77 56 7 243 217 5 0 0 0 0 0 0 0 0 0 0 0 0
72 56 7 245 220 5 0 0 0 0 0 0 0 0 0 0 0 0
67 56 7 247 223 5 0 0 0 0 0 0 0 0 0 0 0 0
62 56 7 249 226 5 0 0 0 0 0 0 0 0 0 0 0 0
57 56 7 251 229 5 0 1 20 1 36 1 0 1 32 0 48 0

//--- motion_tracker.sv
`default_nettype none

module motion_tracker
    import tracker_pkg::*;
(
    input  wire logic                   clk_65mhz,
    input  wire logic                   rst,
    input  wire logic                   frame_done,
    input  wire logic                   coord_valid,
    input  wire axis_t                  coord_axis,
    input  wire logic [x_width-1:0]     coord,
    output logic                        gesture_valid,
    output logic                        punch,
    output logic                        kick,
    output logic [motion_width-1:0]     dx_mag,
    output logic                        dx_neg,
    output logic [motion_width-1:0]     dy_mag,
    output logic                        dy_neg
);

    // x result waiting for its y partner
    logic [x_width-1:0] x_pend;
    // current and previous centroid
    logic [x_width-1:0] cur_x;
    logic [y_width-1:0] cur_y;
    logic [x_width-1:0] prev_x;
    logic [y_width-1:0] prev_y;
    logic               have_cur;
    logic               delta_pending;

    // 2-frame delta, sign and magnitude
    logic               step_dx_neg;
    logic               step_dy_neg;
    logic [x_width-1:0] step_dx;
    logic [y_width-1:0] step_dy;

    // updated window sums, sign in the top bit
    logic [motion_width:0] next_dx;
    logic [motion_width:0] next_dy;

    logic [window_cnt_width-1:0] frame_cnt;

    // sign-magnitude add, larger magnitude keeps its sign
    function automatic logic [motion_width:0] sm_add(
        input logic [motion_width-1:0] acc_mag,
        input logic                    acc_neg,
        input logic [motion_width-1:0] d_mag,
        input logic                    d_neg
    );
        logic [motion_width:0] res;
        if (acc_neg == d_neg) begin
            res = {acc_neg, acc_mag + d_mag};
        end else if (acc_mag > d_mag) begin
            res = {acc_neg, acc_mag - d_mag};
        end else begin
            res = {d_neg, d_mag - acc_mag};
        end
        return res;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // centroid history
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_65mhz) begin
        if (coord_valid && coord_axis == axis_x) begin
            x_pend <= coord;
        end
        // y completes the centroid
        if (coord_valid && coord_axis == axis_y) begin
            cur_x <= x_pend;
            cur_y <= coord[y_width-1:0];
            prev_x <= cur_x;
            prev_y <= cur_y;
        end
    end

    // first centroid after reset has nothing to compare against
    always_ff @(posedge clk_65mhz) begin
        if (rst) begin
            have_cur <= 1'b0;
            delta_pending <= 1'b0;
        end else begin
            delta_pending <= coord_valid && coord_axis == axis_y && have_cur;
            if (coord_valid && coord_axis == axis_y) begin
                have_cur <= 1'b1;
            end
        end
    end

    assign step_dx_neg = prev_x > cur_x;
    assign step_dy_neg = prev_y > cur_y;
    assign step_dx = step_dx_neg ? prev_x - cur_x : cur_x - prev_x;
    assign step_dy = step_dy_neg ? prev_y - cur_y : cur_y - prev_y;

    //////////////////////////////////////////////////////////////////////
    // window sums and verdict
    //////////////////////////////////////////////////////////////////////

    // during the verdict cycle a new delta starts the next window from zero
    assign next_dx = gesture_valid ?
        {step_dx_neg, motion_width'(step_dx)} :
        sm_add(dx_mag, dx_neg, motion_width'(step_dx), step_dx_neg);
    assign next_dy = gesture_valid ?
        {step_dy_neg, motion_width'(step_dy)} :
        sm_add(dy_mag, dy_neg, motion_width'(step_dy), step_dy_neg);

    always_ff @(posedge clk_65mhz) begin
        if (rst) begin
            {dx_neg, dx_mag} <= '0;
            {dy_neg, dy_mag} <= '0;
        end else if (delta_pending) begin
            {dx_neg, dx_mag} <= next_dx;
            {dy_neg, dy_mag} <= next_dy;
        end else if (gesture_valid) begin
            // clear after the verdict has been shown
            {dx_neg, dx_mag} <= '0;
            {dy_neg, dy_mag} <= '0;
        end
    end

    // verdict one cycle after every 16th frame_done
    always_ff @(posedge clk_65mhz) begin
        if (rst) begin
            frame_cnt <= '0;
            gesture_valid <= 1'b0;
        end else begin
            gesture_valid <= frame_done &&
                (frame_cnt == window_cnt_width'(window_frames - 1));
            if (frame_done) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

    // horizontal motion is a punch, vertical a kick
    assign punch = gesture_valid && (dx_mag > gesture_limit);
    assign kick = gesture_valid && (dy_mag > gesture_limit);

endmodule

`default_nettype wire

//--- tb_gesture_top.sv
`default_nettype none

module tb_gesture_top
    import tracker_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int frame_cycles = 300;
    localparam int num_frames = 32;
    // whole stimulus plus some slack for reset and the tail
    localparam int timeout_cycles = num_frames * frame_cycles + 1000;

    localparam logic [11:0] red_pixel = 12'hf00;
    localparam logic [11:0] white_pixel = 12'hfff;
    // mid grey fails both marker tests
    localparam logic [11:0] grey_pixel = 12'h888;

    logic                    clk_65mhz = 1'b0;
    logic                    rst;
    logic [11:0]             pixel;
    logic                    pixel_valid;
    logic [x_width-1:0]      x;
    logic [y_width-1:0]      y;
    logic                    frame_done;

    logic                    p1_gesture_valid;
    logic                    p1_punch;
    logic                    p1_kick;
    logic [motion_width-1:0] p1_dx_mag;
    logic                    p1_dx_neg;
    logic [motion_width-1:0] p1_dy_mag;
    logic                    p1_dy_neg;
    logic                    p2_gesture_valid;
    logic                    p2_punch;
    logic                    p2_kick;
    logic [motion_width-1:0] p2_dx_mag;
    logic                    p2_dx_neg;
    logic [motion_width-1:0] p2_dy_mag;
    logic                    p2_dy_neg;

    integer seed;
    int     cycle_count = 0;
    int     frame_cycle = 0;
    int     frame_num = 0;
    logic   checking = 1'b0;
    // high with frame_done on every 16th frame
    logic   window_frame = 1'b0;
    // verdict expected in this cycle
    logic   verdict_due = 1'b0;
    // p1 then p2, each punch kick dx_mag dx_neg dy_mag dy_neg
    int     expect_v [12];

    gesture_top dut (
        .clk_65mhz(clk_65mhz), .rst(rst),
        .pixel(pixel), .pixel_valid(pixel_valid), .x(x), .y(y),
        .frame_done(frame_done),
        .p1_gesture_valid(p1_gesture_valid), .p1_punch(p1_punch), .p1_kick(p1_kick),
        .p1_dx_mag(p1_dx_mag), .p1_dx_neg(p1_dx_neg),
        .p1_dy_mag(p1_dy_mag), .p1_dy_neg(p1_dy_neg),
        .p2_gesture_valid(p2_gesture_valid), .p2_punch(p2_punch), .p2_kick(p2_kick),
        .p2_dx_mag(p2_dx_mag), .p2_dx_neg(p2_dx_neg),
        .p2_dy_mag(p2_dy_mag), .p2_dy_neg(p2_dy_neg)
    );

    always #10 clk_65mhz = ~clk_65mhz;

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            report_failure($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // one stream cycle, 2 ns after the edge
    task automatic drive_cycle(input logic valid, input logic [11:0] colour,
                               input int px, input int py);
        @(posedge clk_65mhz);
        #2;
        pixel_valid = valid;
        pixel = colour;
        x = x_width'(px);
        y = y_width'(py);
        frame_cycle++;
    endtask

    task automatic send_background();
        int bx;
        int by;
        bx = $unsigned($random(seed)) % 320;
        by = $unsigned($random(seed)) % 240;
        drive_cycle(1'b1, grey_pixel, bx, by);
    endtask

    // odd sides put the centroid exactly on the centre
    task automatic draw_square(input int cx, input int cy, input int side,
                               input logic [11:0] colour);
        int x0;
        int y0;
        int i;
        int j;
        x0 = cx - (side - 1) / 2;
        y0 = cy - (side - 1) / 2;
        for (j = 0; j < side; j++) begin
            for (i = 0; i < side; i++) begin
                // grey pixels dropped in at random spots
                if ($random(seed) & 1) begin
                    send_background();
                end
                drive_cycle(1'b1, colour, x0 + i, y0 + j);
            end
        end
    endtask

    // idle padding, then the frame_done pulse
    task automatic end_frame();
        while (frame_cycle < frame_cycles - 1) begin
            drive_cycle(1'b0, 12'h000, 0, 0);
        end
        @(posedge clk_65mhz);
        #2;
        pixel_valid = 1'b0;
        frame_done = 1'b1;
        frame_num++;
        window_frame = (frame_num % window_frames) == 0;
        @(posedge clk_65mhz);
        #2;
        frame_done = 1'b0;
        window_frame = 1'b0;
        // this cycle already belongs to the next frame
        frame_cycle = 1;
    endtask

    task automatic check_window();
        compare_value("p1_punch", int'(p1_punch), expect_v[0]);
        compare_value("p1_kick", int'(p1_kick), expect_v[1]);
        compare_value("p1_dx_mag", int'(p1_dx_mag), expect_v[2]);
        compare_value("p1_dx_neg", int'(p1_dx_neg), expect_v[3]);
        compare_value("p1_dy_mag", int'(p1_dy_mag), expect_v[4]);
        compare_value("p1_dy_neg", int'(p1_dy_neg), expect_v[5]);
        compare_value("p2_punch", int'(p2_punch), expect_v[6]);
        compare_value("p2_kick", int'(p2_kick), expect_v[7]);
        compare_value("p2_dx_mag", int'(p2_dx_mag), expect_v[8]);
        compare_value("p2_dx_neg", int'(p2_dx_neg), expect_v[9]);
        compare_value("p2_dy_mag", int'(p2_dy_mag), expect_v[10]);
        compare_value("p2_dy_neg", int'(p2_dy_neg), expect_v[11]);
    endtask

    //////////////////////////////////////////////////////////////////////
    // monitors
    //////////////////////////////////////////////////////////////////////

    // verdict due one cycle after a window's last frame_done
    always @(posedge clk_65mhz) begin
        verdict_due <= frame_done && window_frame;
    end

    always @(posedge clk_65mhz) begin
        cycle_count++;
        assert (cycle_count < timeout_cycles) else begin
            report_failure($sformatf("timeout after %0d cycles, frames not finished",
                                     cycle_count));
        end
    end

    // outputs settle by the falling edge
    always @(negedge clk_65mhz) begin
        if (checking) begin
            assert (p1_gesture_valid == verdict_due) else begin
                report_failure($sformatf("mismatch p1_gesture_valid: got 0x%0h, expected 0x%0h",
                                         p1_gesture_valid, verdict_due));
            end
            assert (p2_gesture_valid == verdict_due) else begin
                report_failure($sformatf("mismatch p2_gesture_valid: got 0x%0h, expected 0x%0h",
                                         p2_gesture_valid, verdict_due));
            end
            if (!verdict_due) begin
                assert (!(p1_punch || p1_kick || p2_punch || p2_kick)) else begin
                    report_failure("punch or kick raised outside a verdict cycle");
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        integer fd;
        int status;
        int fields;
        logic [8*256-1:0] line_buf;
        int pos [6];
        seed = 32'hab701271;
        rst = 1'b1;
        pixel = '0;
        pixel_valid = 1'b0;
        x = '0;
        y = '0;
        frame_done = 1'b0;
        repeat (4) @(posedge clk_65mhz);
        #2;
        rst = 1'b0;
        checking = 1'b1;
        frame_cycle = 1;
        fd = $fopen("gesture_vectors.txt", "r");
        if (fd == 0) begin
            report_failure("could not open gesture_vectors.txt");
        end
        while (!$feof(fd)) begin
            line_buf = '0;
            status = $fgets(line_buf, fd);
            fields = $sscanf(line_buf,
                "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                pos[0], pos[1], pos[2], pos[3], pos[4], pos[5],
                expect_v[0], expect_v[1], expect_v[2], expect_v[3],
                expect_v[4], expect_v[5], expect_v[6], expect_v[7],
                expect_v[8], expect_v[9], expect_v[10], expect_v[11]);
            // comment and blank lines yield no fields
            if (status > 0 && fields == 18) begin
                draw_square(pos[0], pos[1], pos[2], red_pixel);
                draw_square(pos[3], pos[4], pos[5], white_pixel);
                end_frame();
                if (frame_num % window_frames == 0) begin
                    check_window();
                end
            end
        end
        $fclose(fd);
        repeat (4) @(posedge clk_65mhz);
        if (frame_num == num_frames) begin
            $display("all tests passed");
            $finish;
        end else begin
            report_failure($sformatf("vectors file held %0d frames instead of %0d",
                                     frame_num, num_frames));
        end
    end

endmodule

`default_nettype wire

//--- tracker_pkg.sv
`default_nettype none

package tracker_pkg;

    //////////////////////////////////////////////////////////////////////
    // image geometry and accumulator widths
    //////////////////////////////////////////////////////////////////////

    // 320x240 camera image
    localparam int x_width = 9;
    localparam int y_width = 8;

    // marker pixels per frame
    localparam int count_width = 16;
    // coordinate sum over one frame
    localparam int sum_width = 24;
    // divider step counter, one quotient bit per step
    localparam int div_step_width = $clog2(sum_width);

    //////////////////////////////////////////////////////////////////////
    // marker colour thresholds, 4 bits per channel
    //////////////////////////////////////////////////////////////////////

    localparam logic [3:0] colour_hi = 4'd12;
    localparam logic [3:0] colour_lo = 4'd3;

    // smaller blobs are treated as noise
    localparam logic [count_width-1:0] min_blob_pixels = count_width'(5);

    //////////////////////////////////////////////////////////////////////
    // motion window
    //////////////////////////////////////////////////////////////////////

    localparam int window_frames = 16;
    localparam int window_cnt_width = $clog2(window_frames);
    localparam int motion_width = 13;
    // window magnitude above this counts as a gesture
    localparam logic [motion_width-1:0] gesture_limit = motion_width'('h20);

    // player 1 wears red, player 2 white
    typedef enum logic {
        marker_red,
        marker_white
    } marker_t;

    // which centroid coordinate a division belongs to
    typedef enum logic {
        axis_x,
        axis_y
    } axis_t;

endpackage

`default_nettype wire
